// File: fetch_pkg.sv
package fetch_pkg;

  // pre-decode result
  typedef enum logic [1:0] {
    CLS_PLAIN,
    CLS_CTRL,
    CLS_LOAD,
    CLS_FENCE_I
  } inst_class_e;

  // rv32 major opcodes seen by the front end
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b0000011,
    OP_MISC_MEM = 7'b0001111,
    OP_STORE    = 7'b0100011,
    OP_BRANCH   = 7'b1100011,
    OP_JALR     = 7'b1100111,
    OP_JAL      = 7'b1101111,
    OP_SYSTEM   = 7'b1110011
  } opcode_e;

  typedef enum logic {
    RES_REDIRECT,
    RES_RETIRE
  } res_kind_e;

  typedef struct packed {
    logic        arvalid;
    logic [31:0] araddr;
    logic [2:0]  arprot;
  } axil_ar_t;

  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_r_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    logic        spec;
  } fetch_pkt_t;

  // target is the real next pc of the resolved instruction
  typedef struct packed {
    logic        valid;
    res_kind_e   kind;
    logic [31:0] pc;
    logic [31:0] target;
  } resolve_t;

  typedef struct packed {
    logic good;
    logic bad;
  } flush_t;

  localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage

// File: fetch_ctrl.sv
`timescale 1ns/1ns

module fetch_ctrl import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        hit_i,
  input  logic [31:0] inst_i,
  input  logic        fill_busy_i,
  output logic [31:0] fetch_pc_o,
  output logic        inval_o,
  input  logic        btb_hit_i,
  input  logic [31:0] btb_target_i,
  output resolve_t    train_o,
  output fetch_pkt_t  pkt_o,
  output logic        pkt_valid_o,
  input  logic        pkt_ready_i,
  input  resolve_t    resolve_i,
  output flush_t      flush_o
);

  logic [31:0] pc_q;
  logic        stall_q;
  logic        spec_q;
  logic [31:0] spec_target_q;
  logic [31:0] spec_fall_q;
  flush_t      flush_q;

  inst_class_e cls;
  logic        is_store;
  logic        hold_back;
  logic        fire;
  logic [31:0] res_next;
  logic        res_match;
  logic        res_bad;

  function automatic inst_class_e classify(input logic [31:0] inst);
    opcode_e op;
    op = opcode_e'(inst[6:0]);
    case (op)
      OP_JAL, OP_JALR, OP_BRANCH, OP_SYSTEM: classify = CLS_CTRL;
      OP_LOAD: classify = CLS_LOAD;
      // funct3 001 is fence.i, plain fence just flows
      OP_MISC_MEM: classify = (inst[14:12] == 3'b001) ? CLS_FENCE_I : CLS_PLAIN;
      default: classify = CLS_PLAIN;
    endcase
  endfunction

  assign cls      = classify(inst_i);
  assign is_store = (inst_i[6:0] == OP_STORE);

  // next pc as given by the back end
  assign res_next = (resolve_i.kind == RES_REDIRECT) ? resolve_i.target
                                                     : resolve_i.pc + 32'd4;

  // only the speculating instruction is unresolved while spec is open
  assign res_match = spec_q & resolve_i.valid & (resolve_i.pc + 32'd4 == spec_fall_q);
  assign res_bad   = res_match & (res_next != spec_target_q);

  // no memory ops, fences or second speculation under an open one
  assign hold_back = spec_q & ((cls != CLS_PLAIN) | is_store);

  assign pkt_valid_o = hit_i & ~fill_busy_i & ~stall_q & ~res_bad & ~hold_back;
  assign fire        = pkt_valid_o & pkt_ready_i;
  assign pkt_o       = '{pc: pc_q, inst: inst_i, spec: spec_q};

  assign fetch_pc_o = pc_q;
  assign inval_o    = fire & (cls == CLS_FENCE_I);
  assign flush_o    = flush_q;

  // btb learns from redirects only
  always_comb begin
    train_o       = resolve_i;
    train_o.valid = resolve_i.valid & (resolve_i.kind == RES_REDIRECT);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q    <= RESET_PC;
      stall_q <= 1'b0;
      spec_q  <= 1'b0;
      flush_q <= '0;
    end else begin
      flush_q.good <= res_match & ~res_bad;
      flush_q.bad  <= res_bad;
      if (res_bad) begin
        // squash and restart at the real target
        pc_q   <= res_next;
        spec_q <= 1'b0;
      end else if (stall_q) begin
        if (resolve_i.valid) begin
          pc_q    <= res_next;
          stall_q <= 1'b0;
        end
      end else begin
        if (res_match) begin
          spec_q <= 1'b0;
        end
        if (fire) begin
          case (cls)
            CLS_PLAIN: pc_q <= pc_q + 32'd4;
            CLS_CTRL: begin
              if (btb_hit_i) begin
                pc_q          <= btb_target_i;
                spec_q        <= 1'b1;
                spec_target_q <= btb_target_i;
                spec_fall_q   <= pc_q + 32'd4;
              end else begin
                stall_q <= 1'b1;
              end
            end
            default: stall_q <= 1'b1;
          endcase
        end
      end
    end
  end

endmodule

// File: l1i_cache.sv
`timescale 1ns/1ns

module l1i_cache #(
  parameter int SET_BITS = 2
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] addr_i,
  input  logic        inval_i,
  output logic        hit_o,
  output logic [31:0] inst_o,
  output logic        fill_busy_o,
  output logic        fill_req_o,
  output logic [31:3] fill_addr_o,
  input  logic [31:0] fill_word_i,
  input  logic        fill_idx_i,
  input  logic        fill_we_i,
  input  logic        fill_done_i
);

  localparam int SETS  = 1 << SET_BITS;
  localparam int TAG_W = 32 - SET_BITS - 3;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_FILL,
    ST_COMMIT
  } fill_state_e;

  fill_state_e state_q;

  logic [31:0]      data_q [SETS][2];
  logic [TAG_W-1:0] tag_q [SETS];
  logic [SETS-1:0]  valid_q;

  logic [31:3]      fill_line_q;
  logic             hold_q;
  logic [31:0]      hold_pc_q;

  logic [SET_BITS-1:0] idx;
  logic [TAG_W-1:0]    tag;
  logic [SET_BITS-1:0] fill_set;
  logic                blocked;

  assign idx      = addr_i[SET_BITS+2:3];
  assign tag      = addr_i[31:SET_BITS+3];
  assign fill_set = fill_line_q[SET_BITS+2:3];

  assign hit_o  = valid_q[idx] & (tag_q[idx] == tag);
  assign inst_o = data_q[idx][addr_i[2]];

  // after fence.i, no refill until fetch moves past the fence
  assign blocked = hold_q & (addr_i == hold_pc_q);

  assign fill_req_o  = (state_q == ST_IDLE) & ~hit_o & ~blocked;
  assign fill_addr_o = addr_i[31:3];
  assign fill_busy_o = (state_q == ST_WAIT_FILL);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      valid_q <= '0;
      hold_q  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (fill_req_o) begin
            // line gets overwritten, drop it now
            valid_q[idx] <= 1'b0;
            state_q      <= ST_WAIT_FILL;
          end
        end
        ST_WAIT_FILL: begin
          if (fill_done_i) begin
            valid_q[fill_set] <= 1'b1;
            state_q           <= ST_COMMIT;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
      if (hold_q & (addr_i != hold_pc_q)) begin
        hold_q <= 1'b0;
      end
      if (inval_i) begin
        valid_q <= '0;
        hold_q  <= 1'b1;
      end
    end
  end

  // payload arrays
  always_ff @(posedge clk) begin
    if (fill_req_o) begin
      fill_line_q <= addr_i[31:3];
    end
    if (inval_i) begin
      hold_pc_q <= addr_i;
    end
    if ((state_q == ST_WAIT_FILL) & fill_we_i) begin
      data_q[fill_set][fill_idx_i] <= fill_word_i;
    end
    if ((state_q == ST_WAIT_FILL) & fill_done_i) begin
      tag_q[fill_set] <= fill_line_q[31:SET_BITS+3];
    end
  end

endmodule

// File: axil_refill.sv
`timescale 1ns/1ns

module axil_refill import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        req_i,
  input  logic [31:3] line_addr_i,
  output logic [31:0] word_o,
  output logic        idx_o,
  output logic        we_o,
  output logic        done_o,
  output axil_ar_t    ar_o,
  input  logic        ar_ready_i,
  input  axil_r_t     r_i,
  output logic        r_ready_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA
  } state_e;

  state_e      state_q;
  logic [31:3] line_q;
  logic        word_q;
  logic        done_q;
  logic        beat;

  // unprivileged, secure, instruction
  assign ar_o = '{arvalid: (state_q == ST_ADDR),
                  araddr:  {line_q, word_q, 2'b00},
                  arprot:  3'b100};

  assign r_ready_o = (state_q == ST_DATA);
  assign beat      = r_ready_o & r_i.rvalid;

  assign word_o = r_i.rdata;
  assign idx_o  = word_q;
  assign we_o   = beat;
  assign done_o = done_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      word_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= beat & word_q;
      case (state_q)
        ST_IDLE: begin
          if (req_i) begin
            line_q  <= line_addr_i;
            word_q  <= 1'b0;
            state_q <= ST_ADDR;
          end
        end
        ST_ADDR: if (ar_ready_i) state_q <= ST_DATA;
        ST_DATA: begin
          if (beat) begin
            // word 0 done, go read word 1
            word_q  <= ~word_q;
            state_q <= word_q ? ST_IDLE : ST_ADDR;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: btb.sv
`timescale 1ns/1ns

module btb import fetch_pkg::*; #(
  parameter int BTB_BITS = 2
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] pc_i,
  output logic        hit_o,
  output logic [31:0] target_o,
  input  resolve_t    train_i
);

  localparam int ENTRIES = 1 << BTB_BITS;
  localparam int TAG_W   = 30 - BTB_BITS;

  logic [ENTRIES-1:0] valid_q;
  logic [TAG_W-1:0]   tag_q [ENTRIES];
  logic [31:0]        target_q [ENTRIES];

  logic [BTB_BITS-1:0] rd_idx;
  logic [BTB_BITS-1:0] wr_idx;

  // index skips the word offset
  assign rd_idx = pc_i[BTB_BITS+1:2];
  assign wr_idx = train_i.pc[BTB_BITS+1:2];

  assign hit_o    = valid_q[rd_idx] & (tag_q[rd_idx] == pc_i[31:BTB_BITS+2]);
  assign target_o = target_q[rd_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (train_i.valid) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // last redirect wins
  always_ff @(posedge clk) begin
    if (train_i.valid) begin
      tag_q[wr_idx]    <= train_i.pc[31:BTB_BITS+2];
      target_q[wr_idx] <= train_i.target;
    end
  end

endmodule

// File: fetch_top.sv
`timescale 1ns/1ns

module fetch_top import fetch_pkg::*; #(
  parameter int SET_BITS = 2,
  parameter int BTB_BITS = 2
) (
  input  logic       clk,
  input  logic       rst,
  output axil_ar_t   ar_o,
  input  logic       ar_ready_i,
  input  axil_r_t    r_i,
  output logic       r_ready_o,
  output fetch_pkt_t pkt_o,
  output logic       pkt_valid_o,
  input  logic       pkt_ready_i,
  input  resolve_t   resolve_i,
  output flush_t     flush_o
);

  logic [31:0] fetch_pc;
  logic        hit;
  logic [31:0] inst;
  logic        fill_busy;
  logic        inval;
  logic        btb_hit;
  logic [31:0] btb_target;
  resolve_t    train;

  logic        fill_req;
  logic [31:3] fill_addr;
  logic [31:0] fill_word;
  logic        fill_idx;
  logic        fill_we;
  logic        fill_done;

  fetch_ctrl fetch_ctrl_i (
    .clk, .rst,
    .hit_i(hit), .inst_i(inst), .fill_busy_i(fill_busy),
    .fetch_pc_o(fetch_pc), .inval_o(inval),
    .btb_hit_i(btb_hit), .btb_target_i(btb_target), .train_o(train),
    .pkt_o, .pkt_valid_o, .pkt_ready_i,
    .resolve_i, .flush_o
  );

  l1i_cache #(.SET_BITS(SET_BITS)) l1i_cache_i (
    .clk, .rst,
    .addr_i(fetch_pc), .inval_i(inval),
    .hit_o(hit), .inst_o(inst), .fill_busy_o(fill_busy),
    .fill_req_o(fill_req), .fill_addr_o(fill_addr),
    .fill_word_i(fill_word), .fill_idx_i(fill_idx),
    .fill_we_i(fill_we), .fill_done_i(fill_done)
  );

  axil_refill axil_refill_i (
    .clk, .rst,
    .req_i(fill_req), .line_addr_i(fill_addr),
    .word_o(fill_word), .idx_o(fill_idx), .we_o(fill_we), .done_o(fill_done),
    .ar_o, .ar_ready_i, .r_i, .r_ready_o
  );

  btb #(.BTB_BITS(BTB_BITS)) btb_i (
    .clk, .rst,
    .pc_i(fetch_pc), .hit_o(btb_hit), .target_o(btb_target),
    .train_i(train)
  );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: tb_checker.sv
`timescale 1ns/1ns

module tb_checker import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  fetch_pkt_t  pkt_i,
  input  logic        pkt_valid_i,
  input  logic        pkt_ready_i,
  input  resolve_t    resolve_i,
  input  flush_t      flush_i,
  input  axil_ar_t    ar_i,
  input  logic        ar_ready_i,
  input  axil_r_t     r_i,
  input  logic        r_ready_i,
  input  logic [31:0] mem_i [64],
  input  logic [1:0]  cls_i [64],
  input  logic        report_i,
  output int          commits_o,
  output int          errors_o
);

  localparam logic [1:0] K_PLAIN = 2'd0;
  localparam logic [1:0] K_CTRL  = 2'd1;
  localparam logic [1:0] K_FENCE = 2'd3;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] exp;
    logic [1:0]  cls;
  } spec_ent_t;

  spec_ent_t   spec_q [$];
  int          checks [5];
  int          errs [5];
  logic [31:0] arch_pc, pred_tgt;
  logic        wait_res, pred_pend, pred_hit, spec_open;
  flush_t      exp_flush;
  logic [3:0]  bv, cv;
  logic [31:0] bpc [4];
  logic [31:0] btgt [4];
  logic [31:3] ctag [4];
  logic [31:3] rd_line;
  logic        rd_word, held_v, held_arv, res_prev;
  fetch_pkt_t  held_pkt;
  axil_ar_t    held_ar;

  assign errors_o = errs[0] + errs[1] + errs[2] + errs[3] + errs[4];

  task automatic error(input int b, input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    errs[b]++;
  endtask

  // in-order commit against the architectural pc sequence
  task automatic commit(input spec_ent_t e);
    checks[0]++;
    if (e.pc != arch_pc)
      error(0, $sformatf("committed pc %h, expected %h", e.pc, arch_pc));
    else if (e.inst != e.exp)
      error(0, $sformatf("inst at %h is %h, memory holds %h", e.pc, e.inst, e.exp));
    if (e.cls == K_PLAIN) arch_pc = e.pc + 32'd4;
    else wait_res = 1'b1;
    commits_o++;
  endtask

  function automatic string behavior_name(input int b);
    case (b)
      0: return "committed stream";
      1: return "prediction";
      2: return "recovery";
      3: return "cache reuse";
      default: return "handshake stability";
    endcase
  endfunction

  always @(posedge clk) begin
    spec_ent_t   e;
    logic [31:0] nxt;
    logic [1:0]  s;
    if (rst) begin
      arch_pc = RESET_PC;
      {wait_res, pred_pend, pred_hit, spec_open, rd_word, held_v, held_arv, res_prev} = '0;
      exp_flush = '0;
      bv = '0;
      cv = '0;
      commits_o = 0;
      spec_q.delete();
    end else begin
      if (flush_i != exp_flush)
        error(2, $sformatf("flush good/bad is %b, expected %b", flush_i, exp_flush));
      exp_flush = '0;
      // a resolution may legally drop or retag the offered packet
      if (held_v && !res_prev && !resolve_i.valid) begin
        checks[4]++;
        if (!pkt_valid_i || pkt_i != held_pkt) error(4, "fetch packet changed while stalled");
      end
      if (held_arv) begin
        checks[4]++;
        if (ar_i != held_ar) error(4, "read address changed before ar_ready");
      end
      held_v = pkt_valid_i && !pkt_ready_i;
      held_pkt = pkt_i;
      held_arv = ar_i.arvalid && !ar_ready_i;
      held_ar = ar_i;
      res_prev = resolve_i.valid;

      if (r_i.rvalid && r_ready_i && !rd_word) begin
        cv[rd_line[4:3]] = 1'b1;
        ctag[rd_line[4:3]] = rd_line;
      end
      if (ar_i.arvalid && ar_ready_i) begin
        checks[3]++;
        s = ar_i.araddr[4:3];
        if (!ar_i.arprot[2]) error(3, "fill read not marked as instruction access");
        if (!rd_word) begin
          if (cv[s] && ctag[s] == ar_i.araddr[31:3])
            error(3, $sformatf("read of %h for a line already cached", ar_i.araddr));
          if (ar_i.araddr[2]) error(3, "line fill did not start at word 0");
          rd_line = ar_i.araddr[31:3];
          cv[s] = 1'b0;
        end else if (ar_i.araddr != {rd_line, 3'b100}) begin
          error(3, $sformatf("second fill read at %h, line %h", ar_i.araddr, {rd_line, 3'b0}));
        end
        rd_word = !rd_word;
      end

      if (pkt_valid_i && pkt_ready_i) begin
        e = '{pc: pkt_i.pc, inst: pkt_i.inst, exp: mem_i[pkt_i.pc[7:2]],
              cls: cls_i[pkt_i.pc[7:2]]};
        checks[3]++;
        s = pkt_i.pc[4:3];
        if (!(cv[s] && ctag[s] == pkt_i.pc[31:3]))
          error(3, $sformatf("packet at %h from a line never filled", pkt_i.pc));
        if (pred_pend) begin
          checks[1]++;
          if (pkt_i.spec != pred_hit)
            error(1, $sformatf("spec bit %b after control transfer, expected %b",
                               pkt_i.spec, pred_hit));
          else if (pred_hit && pkt_i.pc != pred_tgt)
            error(1, $sformatf("speculative pc %h, predicted %h", pkt_i.pc, pred_tgt));
          pred_pend = 1'b0;
        end
        if (pkt_i.spec) begin
          if (!spec_open) error(1, "spec packet with no open speculation");
          if (e.cls != K_PLAIN) error(1, "non-plain instruction issued under speculation");
          spec_q.push_back(e);
        end else begin
          if (spec_open || wait_res) error(0, "packet issued while fetch should wait");
          commit(e);
          if (e.cls == K_CTRL) begin
            pred_pend = 1'b1;
            pred_hit = bv[e.pc[3:2]] && bpc[e.pc[3:2]] == e.pc;
            pred_tgt = btgt[e.pc[3:2]];
            spec_open = pred_hit;
          end
          if (e.cls == K_FENCE) cv = '0;
        end
      end

      if (resolve_i.valid) begin
        nxt = (resolve_i.kind == RES_REDIRECT) ? resolve_i.target : resolve_i.pc + 32'd4;
        arch_pc = nxt;
        wait_res = 1'b0;
        pred_pend = 1'b0;
        checks[2]++;
        if (spec_open) begin
          exp_flush.good = (nxt == pred_tgt);
          exp_flush.bad = (nxt != pred_tgt);
          while (spec_q.size() > 0) begin
            e = spec_q.pop_front();
            if (exp_flush.good) commit(e);
          end
          spec_open = 1'b0;
        end
        if (resolve_i.kind == RES_REDIRECT) begin
          bv[resolve_i.pc[3:2]] = 1'b1;
          bpc[resolve_i.pc[3:2]] = resolve_i.pc;
          btgt[resolve_i.pc[3:2]] = resolve_i.target;
        end
      end
    end
  end

  always @(posedge report_i) begin
    for (int b = 0; b < 5; b++)
      $display("%s: %0d checks, %0d errors", behavior_name(b), checks[b], errs[b]);
    $display("total: %0d commits, %0d checks, %0d errors", commits_o,
             checks[0] + checks[1] + checks[2] + checks[3] + checks[4], errors_o);
  end

endmodule

// File: tb_fetch_top.sv
`timescale 1ns/1ns

module tb_fetch_top import fetch_pkg::*; ();

  localparam int N_COMMITS = 400;
  localparam int WATCH_NS  = N_COMMITS * 40 * 4;

  localparam logic [1:0] K_PLAIN = 2'd0;
  localparam logic [1:0] K_CTRL  = 2'd1;
  localparam logic [1:0] K_LOAD  = 2'd2;
  localparam logic [1:0] K_FENCE = 2'd3;

  logic        clk, rst;
  axil_ar_t    ar_s;
  logic        ar_ready = 1'b0;
  axil_r_t     r_s = '0;
  logic        r_ready;
  fetch_pkt_t  pkt;
  logic        pkt_valid;
  logic        pkt_ready = 1'b0;
  resolve_t    resolve = '0;
  flush_t      flush;

  logic [31:0] mem [64];
  logic [1:0]  mem_cls [64];
  logic [31:0] tgt [64];
  logic        loaded = 1'b0;
  logic        report = 1'b0;
  int          commits, errors;

  logic        res_pend = 1'b0;
  logic [1:0]  res_wait;
  logic        res_fence;
  resolve_t    res_hold;
  logic [31:0] rd_addr;
  logic        r_pend = 1'b0;
  logic [1:0]  ar_wait = 2'd0;
  logic [1:0]  r_wait;

  tb_clk_gen clk_gen_i (.clk, .rst);

  fetch_top #(.SET_BITS(2), .BTB_BITS(2)) fetch_top_i (
    .clk, .rst,
    .ar_o(ar_s), .ar_ready_i(ar_ready), .r_i(r_s), .r_ready_o(r_ready),
    .pkt_o(pkt), .pkt_valid_o(pkt_valid), .pkt_ready_i(pkt_ready),
    .resolve_i(resolve), .flush_o(flush)
  );

  tb_checker checker_i (
    .clk, .rst, .pkt_i(pkt), .pkt_valid_i(pkt_valid), .pkt_ready_i(pkt_ready),
    .resolve_i(resolve), .flush_i(flush), .ar_i(ar_s), .ar_ready_i(ar_ready),
    .r_i(r_s), .r_ready_i(r_ready), .mem_i(mem), .cls_i(mem_cls),
    .report_i(report), .commits_o(commits), .errors_o(errors)
  );

  // 60/20/10/10 mix
  function automatic logic [1:0] pick_class();
    int unsigned r;
    r = $urandom % 10;
    if (r < 6) return K_PLAIN;
    if (r < 8) return K_CTRL;
    if (r < 9) return K_LOAD;
    return K_FENCE;
  endfunction

  function automatic logic [31:0] make_inst(input logic [1:0] c);
    logic [31:0] r;
    r = $urandom;
    case (c)
      K_PLAIN: return {r[31:7], 7'b0010011};
      K_CTRL:  return {r[31:7], 7'b1101111};
      K_LOAD:  return {r[31:7], 7'b0000011};
      default: return {r[31:15], 3'b001, r[11:7], 7'b0001111};
    endcase
  endfunction

  // program load and back end
  always @(posedge clk) begin
    logic [1:0]  c;
    int unsigned k;
    if (rst) begin
      if (!loaded) begin
        for (int i = 0; i < 64; i++) begin
          c = pick_class();
          mem_cls[i] <= c;
          mem[i] <= make_inst(c);
          tgt[i] <= {24'd0, 6'($urandom % 64), 2'b00};
        end
        loaded <= 1'b1;
      end
      pkt_ready <= 1'b0;
      resolve <= '0;
      res_pend <= 1'b0;
    end else begin
      pkt_ready <= ($urandom % 4) != 0;
      resolve <= '0;
      if (res_pend) begin
        if (res_wait == 2'd0) begin
          resolve <= res_hold;
          res_pend <= 1'b0;
          if (res_fence && ($urandom % 2) != 0) begin
            k = $urandom % 64;
            c = pick_class();
            mem[k[5:0]] <= make_inst(c);
            mem_cls[k[5:0]] <= c;
          end
        end else begin
          res_wait <= res_wait - 2'd1;
        end
      end
      if (pkt_valid && pkt_ready && !pkt.spec && mem_cls[pkt.pc[7:2]] != K_PLAIN) begin
        res_pend <= 1'b1;
        res_wait <= 2'($urandom % 4);
        res_fence <= mem_cls[pkt.pc[7:2]] == K_FENCE;
        res_hold.valid <= 1'b1;
        res_hold.pc <= pkt.pc;
        if (mem_cls[pkt.pc[7:2]] == K_CTRL) begin
          res_hold.kind <= RES_REDIRECT;
          // taken three times out of four
          res_hold.target <= (($urandom % 4) != 0) ? tgt[pkt.pc[7:2]] : pkt.pc + 32'd4;
        end else begin
          res_hold.kind <= RES_RETIRE;
          res_hold.target <= pkt.pc + 32'd4;
        end
      end
    end
  end

  // axi4-lite memory with random ar_ready and rvalid delays
  always @(posedge clk) begin
    if (rst) begin
      ar_ready <= 1'b0;
      r_s <= '0;
      r_pend <= 1'b0;
      ar_wait <= 2'd0;
    end else begin
      ar_ready <= 1'b0;
      if (ar_s.arvalid && !ar_ready) begin
        if (ar_wait == 2'd0) ar_ready <= 1'b1;
        else ar_wait <= ar_wait - 2'd1;
      end
      if (ar_s.arvalid && ar_ready) begin
        rd_addr <= ar_s.araddr;
        r_pend <= 1'b1;
        r_wait <= 2'($urandom % 4);
        ar_wait <= 2'($urandom % 4);
      end
      if (r_s.rvalid) begin
        if (r_ready) r_s.rvalid <= 1'b0;
      end else if (r_pend) begin
        if (r_wait == 2'd0) begin
          r_s.rvalid <= 1'b1;
          r_s.rdata <= mem[rd_addr[7:2]];
          r_s.rresp <= 2'b00;
          r_pend <= 1'b0;
        end else begin
          r_wait <= r_wait - 2'd1;
        end
      end
    end
  end

  initial begin
    void'($urandom(32'h1ab7_ddf4));
    wait (!rst);
    wait (commits >= N_COMMITS);
    report = 1'b1;
    #1;
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCH_NS);
    $display("watchdog: only %0d of %0d commits after %0d ns, fetch is hung",
             commits, N_COMMITS, WATCH_NS);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: flist.f
fetch_pkg.sv
fetch_ctrl.sv
l1i_cache.sv
axil_refill.sv
btb.sv
fetch_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_fetch_top.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_fetch_top -f flist.f -o sim_fetch
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_fetch)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1
